/* logic/hex_loader_pkg.sv */
package hex_loader_pkg;

    // --------------------------------------------------
    // timing, kept short so simulation runs quickly

    localparam int clocks_per_bit = 16;
    localparam int timeout_cycles = 2000;
    localparam int refresh_cycles = 8;

    // --------------------------------------------------
    // sizes

    localparam int w_digit = 8;
    localparam int w_word  = 32;

    // abcdefgh, segment a in bit 7, dot in bit 0 and always off
    function automatic logic [7:0] segments_of_hex (input logic [3:0] nibble);
        case (nibble)
            4'h0: return 8'b1111_1100;
            4'h1: return 8'b0110_0000;
            4'h2: return 8'b1101_1010;
            4'h3: return 8'b1111_0010;
            4'h4: return 8'b0110_0110;
            4'h5: return 8'b1011_0110;
            4'h6: return 8'b1011_1110;
            4'h7: return 8'b1110_0000;
            4'h8: return 8'b1111_1110;
            4'h9: return 8'b1111_0110;
            4'ha: return 8'b1110_1110;
            4'hb: return 8'b0011_1110;
            4'hc: return 8'b1001_1100;
            4'hd: return 8'b0111_1010;
            4'he: return 8'b1001_1110;
            default: return 8'b1000_1110;
        endcase
    endfunction

endpackage

/* logic/word_if.sv */
interface word_if;

    import hex_loader_pkg::*;

    // one-cycle write strobe, address and data valid with it
    logic              valid;
    logic [w_word-1:0] address;
    logic [w_word-1:0] data;

    // parser status levels
    logic              busy;
    logic              error;

    modport source
    (
        output valid, address, data, busy, error
    );

    modport sink
    (
        input  valid, address, data, busy, error
    );

endinterface

/* logic/uart_receiver.sv */
module uart_receiver
#(
    parameter int clocks_per_bit = hex_loader_pkg::clocks_per_bit
)
(
    input              clk,
    input              rst,
    input              rx,
    output logic       byte_valid,
    output logic [7:0] byte_data
);

    typedef enum logic [1:0]
    {
        st_idle,
        st_start,
        st_data,
        st_stop
    } state_t;

    state_t state;

    logic rx_meta;
    logic rx_sync;

    logic [$clog2(clocks_per_bit)-1:0] bit_timer;
    logic [2:0]                        bit_index;
    logic [7:0]                        shift;

    logic half_bit_done;
    logic full_bit_done;

    //--------------------------------------------------
    // input synchronizer, line idles high

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
        end
        else
        begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
        end

    assign half_bit_done = bit_timer == clocks_per_bit / 2 - 1;
    assign full_bit_done = bit_timer == clocks_per_bit - 1;

    //--------------------------------------------------
    // framing FSM

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            state      <= st_idle;
            bit_timer  <= '0;
            bit_index  <= '0;
            byte_valid <= 1'b0;
        end
        else
        begin
            byte_valid <= 1'b0;

            case (state)
                st_idle:
                    if (!rx_sync)
                    begin
                        state     <= st_start;
                        bit_timer <= '0;
                    end

                // confirm the start bit at its middle
                st_start:
                    if (half_bit_done)
                    begin
                        bit_timer <= '0;
                        bit_index <= '0;
                        state     <= rx_sync ? st_idle : st_data;
                    end
                    else
                        bit_timer <= bit_timer + 1'b1;

                st_data:
                    if (full_bit_done)
                    begin
                        bit_timer <= '0;
                        bit_index <= bit_index + 1'b1;

                        if (bit_index == 3'd7)
                            state <= st_stop;
                    end
                    else
                        bit_timer <= bit_timer + 1'b1;

                // a low stop bit drops the byte
                default:
                    if (full_bit_done)
                    begin
                        bit_timer  <= '0;
                        state      <= st_idle;
                        byte_valid <= rx_sync;
                    end
                    else
                        bit_timer <= bit_timer + 1'b1;
            endcase
        end

    // lsb first, so new bits enter at the top
    always_ff @(posedge clk)
        if (state == st_data && full_bit_done)
            shift <= { rx_sync, shift [7:1] };

    assign byte_data = shift;

endmodule

/* logic/hex_parser.sv */
module hex_parser
(
    input        clk,
    input        rst,
    input        in_valid,
    input  [7:0] in_char,
    word_if.source words
);

    import hex_loader_pkg::*;

    logic              is_hex;
    logic              is_at;
    logic              is_sep;
    logic [3:0]        nibble;

    logic              token_open;
    logic              token_is_address;
    logic              error_flag;
    logic [w_word-1:0] acc;
    logic [w_word-1:0] cur_address;

    logic [$clog2(timeout_cycles)-1:0] idle_count;

    logic              emit_word;
    logic              load_address;

    logic              write_valid;
    logic [w_word-1:0] write_address;
    logic [w_word-1:0] write_data;

    //--------------------------------------------------
    // character classifier

    assign is_at  = in_char == 8'h40;
    assign is_sep = in_char == 8'h20 || in_char == 8'h0d || in_char == 8'h0a;

    always_comb
    begin
        is_hex = 1'b1;
        nibble = 4'h0;

        if (in_char >= "0" && in_char <= "9")
            nibble = in_char [3:0];
        else if ((in_char >= "a" && in_char <= "f") || (in_char >= "A" && in_char <= "F"))
            nibble = in_char [3:0] + 4'd9;
        else
            is_hex = 1'b0;
    end

    // separator closes an open token
    assign load_address = in_valid && is_sep && token_open &&  token_is_address;
    assign emit_word    = in_valid && is_sep && token_open && !token_is_address;

    //--------------------------------------------------
    // token control, address counter and timeout

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            token_open       <= 1'b0;
            token_is_address <= 1'b0;
            error_flag       <= 1'b0;
            cur_address      <= '0;
            idle_count       <= '0;
            write_valid      <= 1'b0;
        end
        else
        begin
            write_valid <= emit_word;

            if (load_address)
                cur_address <= acc;
            else if (emit_word)
                cur_address <= cur_address + w_word'(4);

            if (in_valid)
            begin
                idle_count <= '0;

                if (is_hex)
                begin
                    token_open <= 1'b1;

                    // a bare digit opens a data word
                    if (!token_open)
                        token_is_address <= 1'b0;
                end
                else if (is_at)
                begin
                    token_open       <= 1'b1;
                    token_is_address <= 1'b1;
                    error_flag       <= 1'b0;
                end
                else if (is_sep)
                    token_open <= 1'b0;
                else
                begin
                    token_open <= 1'b0;
                    error_flag <= 1'b1;
                end
            end
            else if (token_open)
            begin
                if (idle_count == timeout_cycles - 1)
                begin
                    token_open <= 1'b0;
                    error_flag <= 1'b1;
                    idle_count <= '0;
                end
                else
                    idle_count <= idle_count + 1'b1;
            end
        end

    //--------------------------------------------------
    // accumulator and write payload

    // extra digits fall off the top
    always_ff @(posedge clk)
        if (in_valid && is_hex)
            acc <= token_open ? { acc [w_word-5:0], nibble }
                              : { {(w_word-4){1'b0}}, nibble };
        else if (in_valid && is_at)
            acc <= '0;

    always_ff @(posedge clk)
        if (emit_word)
        begin
            write_address <= cur_address;
            write_data    <= acc;
        end

    assign words.valid   = write_valid;
    assign words.address = write_address;
    assign words.data    = write_data;
    assign words.busy    = token_open;
    assign words.error   = error_flag;

endmodule

/* logic/readout_select.sv */
module readout_select
(
    input                                   clk,
    input                                   rst,
    input                                   byte_valid,
    input        [7:0]                      byte_data,
    input        [1:0]                      key,
    word_if.sink                            words,
    output logic [hex_loader_pkg::w_word-1:0] number
);

    import hex_loader_pkg::*;

    logic [w_word-1:0] byte_history;
    logic [w_word-1:0] last_address;
    logic [w_word-1:0] last_data;
    logic [w_word-1:0] write_count;

    //--------------------------------------------------
    // capture registers

    // newest byte in the low end
    always_ff @(posedge clk or posedge rst)
        if (rst)
            byte_history <= '0;
        else if (byte_valid)
            byte_history <= { byte_history [w_word-9:0], byte_data };

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            last_address <= '0;
            last_data    <= '0;
            write_count  <= '0;
        end
        else if (words.valid)
        begin
            last_address <= words.address;
            last_data    <= words.data;
            write_count  <= write_count + 1'b1;
        end

    //--------------------------------------------------
    // key selects what the display shows

    always_ff @(posedge clk or posedge rst)
        if (rst)
            number <= '0;
        else
            case (key)
                2'd0:    number <= byte_history;
                2'd1:    number <= last_address;
                2'd2:    number <= last_data;
                default: number <= write_count;
            endcase

endmodule

/* logic/seven_segment_display.sv */
module seven_segment_display
#(
    parameter int w_digit = hex_loader_pkg::w_digit
)
(
    input                      clk,
    input                      rst,
    input        [31:0]        number,
    output logic [7:0]         abcdefgh,
    output logic [w_digit-1:0] digit
);

    import hex_loader_pkg::*;

    logic [$clog2(refresh_cycles)-1:0] refresh_count;
    logic [$clog2(w_digit)-1:0]        digit_index;
    logic                              advance;
    logic [3:0]                        nibble;

    //--------------------------------------------------
    // refresh timer

    assign advance = refresh_count == refresh_cycles - 1;

    always_ff @(posedge clk or posedge rst)
        if (rst)
            refresh_count <= '0;
        else if (advance)
            refresh_count <= '0;
        else
            refresh_count <= refresh_count + 1'b1;

    //--------------------------------------------------
    // one-hot scan, digit 0 first

    always_ff @(posedge clk or posedge rst)
        if (rst)
        begin
            digit       <= w_digit'(1);
            digit_index <= '0;
        end
        else if (advance)
        begin
            digit <= { digit [w_digit-2:0], digit [w_digit-1] };

            if (digit_index == w_digit - 1)
                digit_index <= '0;
            else
                digit_index <= digit_index + 1'b1;
        end

    // digit i shows bits 4i+3 down to 4i
    assign nibble   = number [digit_index * 4 +: 4];
    assign abcdefgh = segments_of_hex (nibble);

endmodule

/* logic/hex_loader_top.sv */
module hex_loader_top
(
    input                                    clk,
    input                                    rst,
    input                                    uart_rx,
    input        [1:0]                       key,

    output                                   mem_we,
    output       [hex_loader_pkg::w_word-1:0]  mem_address,
    output       [hex_loader_pkg::w_word-1:0]  mem_data,

    output       [1:0]                       status,

    output       [7:0]                       abcdefgh,
    output       [hex_loader_pkg::w_digit-1:0] digit
);

    logic        byte_valid;
    logic [7:0]  byte_data;
    logic [31:0] number;

    word_if words ();

    //--------------------------------------------------
    // serial input and parsing

    uart_receiver receiver
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .rx         ( uart_rx    ),
        .byte_valid ( byte_valid ),
        .byte_data  ( byte_data  )
    );

    hex_parser parser
    (
        .clk      ( clk        ),
        .rst      ( rst        ),
        .in_valid ( byte_valid ),
        .in_char  ( byte_data  ),
        .words    ( words      )
    );

    //--------------------------------------------------
    // readout and display

    readout_select readout
    (
        .clk        ( clk        ),
        .rst        ( rst        ),
        .byte_valid ( byte_valid ),
        .byte_data  ( byte_data  ),
        .key        ( key        ),
        .words      ( words      ),
        .number     ( number     )
    );

    seven_segment_display display
    (
        .clk      ( clk      ),
        .rst      ( rst      ),
        .number   ( number   ),
        .abcdefgh ( abcdefgh ),
        .digit    ( digit    )
    );

    // write port straight from the parser
    assign mem_we      = words.valid;
    assign mem_address = words.address;
    assign mem_data    = words.data;

    // error led in bit 1, busy in bit 0
    assign status = { words.error, words.busy };

endmodule

/* tb/tb_hex_loader.sv */
module tb_hex_loader;

    import hex_loader_pkg::*;

    // long enough for several UART frames or two full display scans
    localparam int write_wait = 4 * 10 * clocks_per_bit;
    localparam int digit_wait = 2 * w_digit * refresh_cycles;

    logic        clk;
    logic        rst;
    logic        uart_rx;
    logic [1:0]  key;
    logic        mem_we;
    logic [31:0] mem_address;
    logic [31:0] mem_data;
    logic [1:0]  status;
    logic [7:0]  abcdefgh;
    logic [7:0]  digit;

    logic [63:0] writes [$];
    int          checks;
    int          errors;

    hex_loader_top UUT
    (
        .clk         ( clk         ),
        .rst         ( rst         ),
        .uart_rx     ( uart_rx     ),
        .key         ( key         ),
        .mem_we      ( mem_we      ),
        .mem_address ( mem_address ),
        .mem_data    ( mem_data    ),
        .status      ( status      ),
        .abcdefgh    ( abcdefgh    ),
        .digit       ( digit       )
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // write monitor with the address in the upper half
    always @(negedge clk)
        if (mem_we === 1'b1)
            writes.push_back({ mem_address, mem_data });

    // --------------------------------------------------
    // reporting

    task automatic check_value
    (
        input string       what,
        input logic [31:0] got,
        input logic [31:0] expected
    );
        checks++;
        assert (got === expected)
            $display("ok   %0t: %s = %h", $time, what, got);
        else
        begin
            $display("FAIL %0t: %s is %h, expected %h", $time, what, got, expected);
            errors++;
        end
    endtask

    task automatic note_failure (input string text);
        checks++;
        errors++;
        $display("problem at %0t: %s", $time, text);
    endtask

    // --------------------------------------------------
    // stimulus

    task automatic after_edge ();
        @(posedge clk);
        #1;
    endtask

    // start bit, eight data bits lsb first, stop bit
    task automatic send_byte (input logic [7:0] value);
        logic [9:0] frame;
        frame = { 1'b1, value, 1'b0 };
        for (int i = 0; i < 10; i++)
        begin
            after_edge ();
            uart_rx = frame [i];
            repeat (clocks_per_bit - 1)
                @(posedge clk);
        end
    endtask

    // --------------------------------------------------
    // response checks

    task automatic expect_write (input logic [31:0] address, input logic [31:0] data);
        int          waited;
        logic [63:0] seen;
        waited = 0;
        while (writes.size() == 0 && waited < write_wait)
        begin
            @(negedge clk);
            waited++;
        end
        if (writes.size() == 0)
            note_failure("no write arrived in time");
        else
        begin
            seen = writes.pop_front();
            check_value("write address", seen [63:32], address);
            check_value("write data", seen [31:0], data);
        end
    endtask

    // abcdefgh pattern back to a nibble with bit 4 set for a known pattern
    function automatic logic [4:0] decode_segments (input logic [7:0] pattern);
        case (pattern)
            8'hfc:   return { 1'b1, 4'h0 };
            8'h60:   return { 1'b1, 4'h1 };
            8'hda:   return { 1'b1, 4'h2 };
            8'hf2:   return { 1'b1, 4'h3 };
            8'h66:   return { 1'b1, 4'h4 };
            8'hb6:   return { 1'b1, 4'h5 };
            8'hbe:   return { 1'b1, 4'h6 };
            8'he0:   return { 1'b1, 4'h7 };
            8'hfe:   return { 1'b1, 4'h8 };
            8'hf6:   return { 1'b1, 4'h9 };
            8'hee:   return { 1'b1, 4'ha };
            8'h3e:   return { 1'b1, 4'hb };
            8'h9c:   return { 1'b1, 4'hc };
            8'h7a:   return { 1'b1, 4'hd };
            8'h9e:   return { 1'b1, 4'he };
            8'h8e:   return { 1'b1, 4'hf };
            default: return 5'h00;
        endcase
    endfunction

    task automatic expect_display (input logic [1:0] select, input logic [31:0] expected);
        logic [31:0] shown;
        logic [4:0]  decoded;
        int          waited;
        bit          complete;
        shown    = '0;
        complete = 1'b1;
        after_edge ();
        key = select;
        // number follows key one clock later
        repeat (2)
            @(negedge clk);
        for (int i = 0; i < w_digit; i++)
        begin
            waited = 0;
            while (digit !== 8'(1 << i) && waited < digit_wait)
            begin
                @(negedge clk);
                waited++;
            end
            decoded = decode_segments(abcdefgh);
            if (digit !== 8'(1 << i))
            begin
                note_failure($sformatf("digit %0d never became active", i));
                complete = 1'b0;
            end
            else if (!decoded [4])
            begin
                note_failure($sformatf("digit %0d shows no hex pattern", i));
                complete = 1'b0;
            end
            else
                shown [4*i +: 4] = decoded [3:0];
        end
        if (complete)
            check_value($sformatf("display key %0d", select), shown, expected);
    endtask

    task automatic expect_status (input string what, input int index, input logic [31:0] value);
        @(negedge clk);
        check_value(what, 32'(status [index]), value);
    endtask

    // --------------------------------------------------
    // testdata interpreter

    task automatic run_record (input string line);
        string       text;
        string       pair;
        logic [31:0] first;
        logic [31:0] second;
        case (line [0])
            "S":
                if ($sscanf(line, "S %s", text) != 1)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    for (int i = 0; i + 1 < text.len(); i += 2)
                    begin
                        pair = text.substr(i, i + 1);
                        send_byte(8'(pair.atohex()));
                    end
            "W":
                if ($sscanf(line, "W %h %h", first, second) != 2)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    expect_write(first, second);
            "K":
                if ($sscanf(line, "K %d %h", first, second) != 2)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    expect_display(first [1:0], second);
            "E":
                if ($sscanf(line, "E %d", first) != 1)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    expect_status("error flag", 1, first);
            "B":
                if ($sscanf(line, "B %d", first) != 1)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    expect_status("busy flag", 0, first);
            "I":
                if ($sscanf(line, "I %d", first) != 1)
                    note_failure($sformatf("malformed record: %s", line));
                else
                    repeat (first)
                        @(posedge clk);
            default:
                note_failure($sformatf("unknown record: %s", line));
        endcase
    endtask

    initial
    begin
        int    fd;
        int    count;
        string line;

        rst     = 1'b1;
        uart_rx = 1'b1;
        key     = 2'd0;
        checks  = 0;
        errors  = 0;

        repeat (4)
            @(posedge clk);
        #1;
        rst = 1'b0;

        fd = $fopen("tb/hex_loader_testdata.txt", "r");
        if (fd == 0)
            note_failure("cannot open tb/hex_loader_testdata.txt");
        else
        begin
            while (!$feof(fd))
            begin
                count = $fgets(line, fd);
                if (count > 1 && line [0] != "#")
                    run_record(line);
            end
            $fclose(fd);
        end

        // give a stray write time to reach the queue
        repeat (20)
            @(negedge clk);
        check_value("writes left unmatched", writes.size(), 0);

        $display("%0d checks run, %0d failed", checks, errors);
        if (errors == 0)
            $display("NO ERRORS");
        else
            $display("ERRORS FOUND");
        $finish;
    end

endmodule

/* tb/hex_loader_testdata.txt */
# S bytes as hex pairs | W address data (hex) | K key number (hex)
# E error 0/1 | B busy 0/1 | I idle clocks (decimal)
S 403030303030303130
B 1
S 20
B 0
E 0
S 444541444245454620
W 00000010 deadbeef
S 313233343536373820
W 00000014 12345678
K 0 36373820
K 1 00000014
K 2 12345678
K 3 00000002
S 313247
E 1
S 20
S 40303030303031303020
E 0
S 414120
W 00000100 000000aa
S 403030303030
B 1
I 2100
E 1
B 0
S 353520
W 00000104 00000055
S 20200d0a
S 3132333435363738392020
W 00000108 23456789
K 3 00000005
K 0 38392020
K 1 00000108
K 2 23456789
E 1

/* hex_loader_top.f */
logic/hex_loader_pkg.sv
logic/word_if.sv
logic/uart_receiver.sv
logic/hex_parser.sv
logic/readout_select.sv
logic/seven_segment_display.sv
logic/hex_loader_top.sv
tb/tb_hex_loader.sv
